// File: common/raster_consts.svh
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Coordinate word width, integer and fraction together
`define RASTER_SIGFIG 24

// Fraction bits at the bottom of a coordinate word
`define RASTER_RADIX 10

// Vertices per triangle
`define RASTER_VERTS 3

// One-hot multisample grid codes
// 1x keeps whole pixels, each step down halves the sample pitch
`define RASTER_MSAA_1X 4'b1000
`define RASTER_MSAA_4X 4'b0100
`define RASTER_MSAA_16X 4'b0010
`define RASTER_MSAA_64X 4'b0001

`endif

// File: common/raster_pkg.sv
`include "raster_consts.svh"

package raster_pkg;

    // Fixed-point split of one coordinate word
    // Integer part carries the sign
    typedef struct packed {
        logic signed [`RASTER_SIGFIG-`RASTER_RADIX-1:0] ipart;
        logic        [`RASTER_RADIX-1:0]                fpart;
    } coord_fix_t;

    // One coordinate, seen as a plain signed word or as its fixed-point fields
    // Word view for compares and clipping, field view for grid flooring
    typedef union packed {
        logic signed [`RASTER_SIGFIG-1:0] word;
        coord_fix_t                       fix;
    } coord_u;

    typedef struct packed {
        coord_u x;
        coord_u y;
        coord_u z;
    } vertex_t;

    // Vertex 0 sits in the low bits
    typedef vertex_t [`RASTER_VERTS-1:0] tri_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        coord_u ll_x;
        coord_u ll_y;
        coord_u ur_x;
        coord_u ur_y;
    } box_t;

    // Largest legal sample position on each axis
    typedef struct packed {
        logic signed [`RASTER_SIGFIG-1:0] width;
        logic signed [`RASTER_SIGFIG-1:0] height;
    } screen_t;

    // One-hot grid select, see RASTER_MSAA_* codes
    typedef logic [3:0] msaa_t;

    // Contents of one pipeline slot
    typedef struct packed {
        logic   valid;
        tri_t   verts;
        box_t   box;
    } bbox_slot_t;

endpackage

// File: bbox/bbox_minmax.sv
`timescale 1ns/100ps
`include "raster_consts.svh"

module bbox_minmax (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   advance,
    input  logic                   in_valid,
    input  raster_pkg::tri_t       in_tri,
    output raster_pkg::bbox_slot_t slot
);

    import raster_pkg::*;

    // Min/max box of the incoming triangle, before the register
    box_t box_c;

    // Start from vertex 0 and only replace on a strict win
    // so a tie keeps the lower-indexed vertex
    always_comb begin
        box_c.ll_x = in_tri[0].x;
        box_c.ur_x = in_tri[0].x;
        box_c.ll_y = in_tri[0].y;
        box_c.ur_y = in_tri[0].y;
        for (int v = 1; v < `RASTER_VERTS; v++) begin
            // Signed word view for all compares
            if (in_tri[v].x.word < box_c.ll_x.word) begin
                box_c.ll_x = in_tri[v].x;
            end
            if (in_tri[v].x.word > box_c.ur_x.word) begin
                box_c.ur_x = in_tri[v].x;
            end
            if (in_tri[v].y.word < box_c.ll_y.word) begin
                box_c.ll_y = in_tri[v].y;
            end
            if (in_tri[v].y.word > box_c.ur_y.word) begin
                box_c.ur_y = in_tri[v].y;
            end
        end
    end

    // First pipe register
    // Holds everything while downstream is not ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot <= '0;
        end else if (advance) begin
            // Empty input still moves through, with valid low
            slot.valid <= in_valid;
            slot.verts <= in_tri;
            slot.box   <= box_c;
        end
    end

endmodule

// File: bbox/bbox_snap.sv
`timescale 1ns/100ps
`include "raster_consts.svh"

module bbox_snap (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   advance,
    input  raster_pkg::msaa_t      msaa,
    input  raster_pkg::bbox_slot_t slot_in,
    output raster_pkg::bbox_slot_t slot_out
);

    import raster_pkg::*;

    // Fraction bits that survive the floor
    logic [`RASTER_RADIX-1:0] frac_mask;
    box_t                     box_snap;

    // Keep 0..3 top fraction bits depending on grid pitch
    always_comb begin
        case (msaa)
            `RASTER_MSAA_4X:  frac_mask = {1'b1, {(`RASTER_RADIX-1){1'b0}}};
            `RASTER_MSAA_16X: frac_mask = {2'b11, {(`RASTER_RADIX-2){1'b0}}};
            `RASTER_MSAA_64X: frac_mask = {3'b111, {(`RASTER_RADIX-3){1'b0}}};
            // 1x and any non-one-hot value floor to whole pixels
            default:          frac_mask = '0;
        endcase
    end

    // Clearing low fraction bits floors toward minus infinity,
    // integer part passes untouched
    always_comb begin
        box_snap = slot_in.box;
        box_snap.ll_x.fix.fpart = slot_in.box.ll_x.fix.fpart & frac_mask;
        box_snap.ll_y.fix.fpart = slot_in.box.ll_y.fix.fpart & frac_mask;
        box_snap.ur_x.fix.fpart = slot_in.box.ur_x.fix.fpart & frac_mask;
        box_snap.ur_y.fix.fpart = slot_in.box.ur_y.fix.fpart & frac_mask;
    end

    // Second pipe register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_out <= '0;
        end else if (advance) begin
            slot_out.valid <= slot_in.valid;
            slot_out.verts <= slot_in.verts;
            slot_out.box   <= box_snap;
        end
    end

endmodule

// File: bbox/bbox_clip.sv
`timescale 1ns/100ps

module bbox_clip (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   advance,
    input  raster_pkg::screen_t    screen,
    input  raster_pkg::bbox_slot_t slot_in,
    output raster_pkg::bbox_slot_t slot_out
);

    import raster_pkg::*;

    logic reject;
    box_t box_clip;

    // Box wholly off one of the four sides
    // Checked on the floored box, before any clamping
    always_comb begin
        reject = 1'b0;
        // Left of the screen
        if (slot_in.box.ur_x.word < 0) begin
            reject = 1'b1;
        end
        // Below the screen
        if (slot_in.box.ur_y.word < 0) begin
            reject = 1'b1;
        end
        // Right of the screen
        if (slot_in.box.ll_x.word > screen.width) begin
            reject = 1'b1;
        end
        // Above the screen
        if (slot_in.box.ll_y.word > screen.height) begin
            reject = 1'b1;
        end
    end

    // Clamp corners into the screen rectangle
    // Lower-left only moves up, upper-right only moves down
    always_comb begin
        box_clip = slot_in.box;
        if (slot_in.box.ll_x.word < 0) begin
            box_clip.ll_x.word = '0;
        end
        if (slot_in.box.ll_y.word < 0) begin
            box_clip.ll_y.word = '0;
        end
        if (slot_in.box.ur_x.word > screen.width) begin
            box_clip.ur_x.word = screen.width;
        end
        if (slot_in.box.ur_y.word > screen.height) begin
            box_clip.ur_y.word = screen.height;
        end
    end

    // Output register of the unit
    // A rejected triangle drops out here with valid low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_out <= '0;
        end else if (advance) begin
            slot_out.valid <= slot_in.valid & ~reject;
            slot_out.verts <= slot_in.verts;
            slot_out.box   <= box_clip;
        end
    end

endmodule

// File: bbox/bbox_top.sv
`timescale 1ns/100ps

module bbox_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  raster_pkg::tri_t    in_tri,
    input  raster_pkg::screen_t screen,
    input  raster_pkg::msaa_t   msaa,
    output logic                out_valid,
    input  logic                out_ready,
    output raster_pkg::tri_t    out_tri,
    output raster_pkg::box_t    out_box
);

    import raster_pkg::*;

    // Whole pipe moves together, or not at all
    logic       advance;
    bbox_slot_t slot_a;
    bbox_slot_t slot_b;
    bbox_slot_t slot_c;

    assign advance  = out_ready;
    // Input is taken on the same edges the pipe shifts
    assign in_ready = out_ready;

    // Min/max corners
    bbox_minmax minmax_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .in_valid (in_valid),
        .in_tri   (in_tri),
        .slot     (slot_a)
    );

    // Floor to sample grid
    bbox_snap snap_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .msaa     (msaa),
        .slot_in  (slot_a),
        .slot_out (slot_b)
    );

    // Screen clip and reject
    bbox_clip clip_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .screen   (screen),
        .slot_in  (slot_b),
        .slot_out (slot_c)
    );

    assign out_valid = slot_c.valid;
    assign out_tri   = slot_c.verts;
    assign out_box   = slot_c.box;

endmodule

// File: tb/bbox_props.sv
`timescale 1ns/100ps

module bbox_props (
    input logic                clk,
    input logic                arst_n,
    input logic                out_valid,
    input logic                out_ready,
    input raster_pkg::tri_t    out_tri,
    input raster_pkg::box_t    out_box,
    input raster_pkg::screen_t screen
);

    // Running count of assertion failures
    int fail_count = 0;

    // Floor and clamp keep the corners ordered
    a_box_order: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (out_box.ll_x.word <= out_box.ur_x.word)
                      && (out_box.ll_y.word <= out_box.ur_y.word))
        else begin
            fail_count++;
            $error("Output box has its lower-left corner past its upper-right corner");
        end

    // Upper-right corner clamped to the screen
    a_box_on_screen: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (out_box.ur_x.word <= screen.width)
                      && (out_box.ur_y.word <= screen.height))
        else begin
            fail_count++;
            $error("Output box reaches past the screen");
        end

    // Stalled outputs hold still
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !out_ready |=> $stable(out_valid) && $stable(out_box) && $stable(out_tri))
        else begin
            fail_count++;
            $error("Outputs changed while out_ready was low");
        end

endmodule

bind bbox_top bbox_props props_i (.*);

// File: tb/bbox_tb.sv
`timescale 1ns/100ps
`include "raster_consts.svh"

module bbox_tb;

    import raster_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int PX = 1 << `RASTER_RADIX;
    localparam int SCR_W = 320 * PX;
    localparam int SCR_H = 240 * PX;
    localparam int N_GRID = 50;
    localparam int N_DIRECTED = 6;
    localparam int N_CLIP = 60;
    localparam int N_BP = 200;
    // Four cycles per triangle covers the stalls
    // Plus a flush per drain
    localparam int STIM_CYCLES = 4 * (1 + 4 * N_GRID + N_DIRECTED + N_CLIP + N_BP) + 8 * 10;
    localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + RESET_CYCLES);
    localparam msaa_t GRID_CODES [4] = '{`RASTER_MSAA_1X, `RASTER_MSAA_4X,
                                         `RASTER_MSAA_16X, `RASTER_MSAA_64X};

    logic    clk = 1'b0;
    logic    arst_n;
    logic    in_valid;
    logic    in_ready;
    tri_t    in_tri;
    screen_t screen;
    msaa_t   msaa;
    logic    out_valid;
    logic    out_ready;
    tri_t    out_tri;
    box_t    out_box;

    int unsigned lcg_state = 48;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          err_mark = 0;
    int          cycles = 0;
    // Expected results of kept triangles in arrival order
    box_t        exp_box_q[$];
    tri_t        exp_tri_q[$];

    bbox_top dut_i (.*);

    always #10 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // Low bits of an LCG cycle too fast
        return lcg_state >> 8;
    endfunction

    task automatic check_value(input string name, input logic [215:0] got,
                               input logic [215:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Reference model applies min/max, grid floor, reject and clip in order
    // Returns 0 when the triangle is dropped
    function automatic bit model_box(input tri_t t, input msaa_t m, input screen_t s,
                                     output box_t b);
        int lx;
        int ux;
        int ly;
        int uy;
        int sh;
        lx = int'(t[0].x.word);
        ux = lx;
        ly = int'(t[0].y.word);
        uy = ly;
        for (int v = 1; v < `RASTER_VERTS; v++) begin
            lx = (int'(t[v].x.word) < lx) ? int'(t[v].x.word) : lx;
            ux = (int'(t[v].x.word) > ux) ? int'(t[v].x.word) : ux;
            ly = (int'(t[v].y.word) < ly) ? int'(t[v].y.word) : ly;
            uy = (int'(t[v].y.word) > uy) ? int'(t[v].y.word) : uy;
        end
        // Grid pitch as a power of two in fraction units
        case (m)
            `RASTER_MSAA_4X:  sh = `RASTER_RADIX - 1;
            `RASTER_MSAA_16X: sh = `RASTER_RADIX - 2;
            `RASTER_MSAA_64X: sh = `RASTER_RADIX - 3;
            default:          sh = `RASTER_RADIX;
        endcase
        // Arithmetic shift floors toward minus infinity
        lx = (lx >>> sh) <<< sh;
        ux = (ux >>> sh) <<< sh;
        ly = (ly >>> sh) <<< sh;
        uy = (uy >>> sh) <<< sh;
        b = '0;
        if (ux < 0 || uy < 0 || lx > int'(s.width) || ly > int'(s.height)) begin
            return 1'b0;
        end
        b.ll_x.word = (lx < 0) ? 24'(0) : lx[23:0];
        b.ll_y.word = (ly < 0) ? 24'(0) : ly[23:0];
        b.ur_x.word = (ux > int'(s.width)) ? s.width : ux[23:0];
        b.ur_y.word = (uy > int'(s.height)) ? s.height : uy[23:0];
        return 1'b1;
    endfunction

    function automatic tri_t rand_tri(input int lo_x, input int span_x,
                                      input int lo_y, input int span_y);
        tri_t t;
        int   c;
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            c = lo_x + int'(lcg_next() % span_x);
            t[v].x.word = c[23:0];
            c = lo_y + int'(lcg_next() % span_y);
            t[v].y.word = c[23:0];
            t[v].z.word = 24'(lcg_next());
        end
        return t;
    endfunction

    // Directed vertices in quarter-pixel units
    function automatic tri_t make_tri(input int x0, input int y0, input int x1,
                                      input int y1, input int x2, input int y2);
        int   q [6];
        int   c;
        tri_t t;
        q = '{x0, y0, x1, y1, x2, y2};
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            c = q[2 * v] * (PX / 4);
            t[v].x.word = c[23:0];
            c = q[2 * v + 1] * (PX / 4);
            t[v].y.word = c[23:0];
            t[v].z.word = 24'(v);
        end
        return t;
    endfunction

    // One triangle taken on the next edge
    task automatic send_one(input tri_t t);
        in_tri <= t;
        in_valid <= 1'b1;
        out_ready <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic stream(input int n, input bit stall, input int lo_x, input int span_x,
                          input int lo_y, input int span_y);
        int acc;
        bit pending;
        bit rdy;
        acc = 0;
        pending = 1'b0;
        while (acc < n) begin
            // A presented triangle stays on the input until taken
            if (!pending) begin
                pending = (lcg_next() % 4) != 0;
                in_valid <= pending;
                if (pending)
                    in_tri <= rand_tri(lo_x, span_x, lo_y, span_y);
            end
            rdy = stall ? ((lcg_next() % 3) != 0) : 1'b1;
            out_ready <= rdy;
            @(posedge clk);
            if (pending && rdy) begin
                acc++;
                pending = 1'b0;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        out_ready <= 1'b1;
        do begin
            @(negedge clk);
        end while (exp_box_q.size() != 0);
        // Wait the pipe depth so rejected slots leave too
        repeat (3) @(posedge clk);
    endtask

    // Scoreboard samples at the edge where each handshake completes
    always @(posedge clk) begin : scoreboard
        box_t eb;
        tri_t et;
        if (arst_n && in_valid && in_ready) begin
            if (model_box(in_tri, msaa, screen, eb)) begin
                exp_box_q.push_back(eb);
                exp_tri_q.push_back(in_tri);
            end
        end
        if (arst_n && out_valid && out_ready) begin
            if (exp_box_q.size() == 0) begin
                errors++;
                $display("Output triangle appeared while none was expected");
            end else begin
                eb = exp_box_q.pop_front();
                et = exp_tri_q.pop_front();
                check_value("out_box", 216'(out_box), 216'(eb));
                check_value("out_tri", 216'(out_tri), 216'(et));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int lat;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_tri = '0;
        screen.width = 24'(SCR_W);
        screen.height = 24'(SCR_H);
        msaa = `RASTER_MSAA_1X;
        out_ready = 1'b0;

        // Nothing comes out during or right after reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", 216'(out_valid), 216'(0));
        end
        @(posedge clk);
        arst_n <= 1'b1;
        out_ready <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 216'(out_valid), 216'(0));
        end
        @(posedge clk);
        end_test("reset");

        // Fractional corners make the 1x floor visible in the box
        send_one(make_tri(41, 43, 402, 101, 203, 302));
        // Edges from acceptance up to the edge that takes the output
        lat = 0;
        @(negedge clk);
        while (!out_valid && lat < 8) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        @(posedge clk);
        lat++;
        check_value("latency", 216'(lat), 216'(3));
        drain();
        end_test("latency");

        // Grid setting only changes with the pipe empty
        for (int g = 0; g < 4; g++) begin
            msaa <= GRID_CODES[g];
            stream(N_GRID, 1'b0, -SCR_W / 2, 2 * SCR_W, -SCR_H / 2, 2 * SCR_H);
            drain();
        end
        end_test("grid flooring");

        msaa <= `RASTER_MSAA_1X;
        // Partly off the left and bottom edges
        send_one(make_tri(-40, -20, 80, 120, 20, -80));
        // Partly off the right and top edges
        send_one(make_tri(1200, 920, 1360, 940, 1240, 1040));
        // Wholly off left as ur_x of -0.25 px floors to -1
        send_one(make_tri(-120, 40, -1, 200, -20, 400));
        // Wholly below
        send_one(make_tri(40, -120, 200, -1, 400, -80));
        // Wholly right and wholly above with corners just past the edge after the floor
        send_one(make_tri(1286, 40, 1320, 200, 1600, 400));
        send_one(make_tri(40, 966, 200, 1040, 400, 1200));
        stream(N_CLIP, 1'b0, -SCR_W, 3 * SCR_W, -SCR_H, 3 * SCR_H);
        drain();
        end_test("clip and reject");

        msaa <= `RASTER_MSAA_16X;
        stream(N_BP, 1'b1, -SCR_W / 2, 2 * SCR_W, -SCR_H / 2, 2 * SCR_H);
        drain();
        end_test("back-pressure");

        if (exp_box_q.size() != 0) begin
            errors++;
            $display("%0d expected triangles never came out", exp_box_q.size());
        end
        if (dut_i.props_i.fail_count != 0) begin
            errors += dut_i.props_i.fail_count;
            $display("%0d output assertions failed", dut_i.props_i.fail_count);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/raster_pkg.sv
bbox/bbox_minmax.sv
bbox/bbox_snap.sv
bbox/bbox_clip.sv
bbox/bbox_top.sv
tb/bbox_props.sv
tb/bbox_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bbox_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard common/*.svh)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
